/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_dcache
FLIST     = flist.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* dcache_arrays.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_arrays (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::index_t    rd_index,
    input  logic                  wr_en,
    input  logic                  wr_way,
    input  dcache_pkg::index_t    wr_index,
    input  dcache_pkg::tag_t      wr_tag,
    input  dcache_pkg::line_t     wr_line,
    input  logic                  wr_dirty,
    input  logic                  victim_flip,
    output dcache_pkg::tag_t  [`DCACHE_WAYS-1:0] rd_tag,
    output dcache_pkg::line_t [`DCACHE_WAYS-1:0] rd_line,
    output logic [`DCACHE_WAYS-1:0] rd_valid,
    output logic [`DCACHE_WAYS-1:0] rd_dirty,
    output logic                  victim_way
);
    import dcache_pkg::*;

    tag_t  tag_mem  [`DCACHE_WAYS][`DCACHE_SETS];
    line_t line_mem [`DCACHE_WAYS][`DCACHE_SETS];

    logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] valid_q;
    logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] dirty_q;
    logic [`DCACHE_SETS-1:0] victim_q;
    index_t idx_q;

    // read address is registered, so a write at the same edge is seen by the read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx_q    <= '0;
            valid_q  <= '0;
            dirty_q  <= '0;
            victim_q <= '0;
        end else begin
            idx_q <= rd_index;
            if (wr_en) begin
                valid_q[wr_way][wr_index] <= 1'b1;
                dirty_q[wr_way][wr_index] <= wr_dirty;
            end
            if (victim_flip) begin
                victim_q[wr_index] <= ~victim_q[wr_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index]  <= wr_tag;
            line_mem[wr_way][wr_index] <= wr_line;
        end
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            rd_tag[w]   = tag_mem[w][idx_q];
            rd_line[w]  = line_mem[w][idx_q];
            rd_valid[w] = valid_q[w][idx_q];
            rd_dirty[w] = dirty_q[w][idx_q];
        end
    end

    // an empty way wins over the round robin bit
    assign victim_way = !rd_valid[0] ? 1'b0 :
                        !rd_valid[1] ? 1'b1 : victim_q[idx_q];

endmodule

/* dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address and data word
`define DCACHE_ADDR_W       32
`define DCACHE_WORD_BYTES   4
`define DCACHE_BYTE_W       2

// line geometry
`define DCACHE_LINE_WORDS   4
`define DCACHE_OFFSET_W     2

// set geometry
`define DCACHE_SETS         16
`define DCACHE_INDEX_W      4
`define DCACHE_WAYS         2

// address less index, word offset and byte bits
`define DCACHE_TAG_W        24

`endif

/* dcache_lookup.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_lookup (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  s1_valid,
    input  dcache_pkg::req_op_e   s1_op,
    input  dcache_pkg::tag_t      s1_tag,
    input  dcache_pkg::index_t    s1_index,
    input  dcache_pkg::offset_t   s1_offset,
    input  dcache_pkg::word_t     s1_wdata,
    input  dcache_pkg::mask_t     s1_mask,
    input  dcache_pkg::tag_t  [`DCACHE_WAYS-1:0] rd_tag,
    input  dcache_pkg::line_t [`DCACHE_WAYS-1:0] rd_line,
    input  logic [`DCACHE_WAYS-1:0] rd_valid,
    input  logic                  freeze,
    output logic                  resp_valid,
    output dcache_pkg::word_t     resp_rdata,
    output logic                  st_wr_en,
    output logic                  st_way,
    output dcache_pkg::index_t    st_index,
    output dcache_pkg::tag_t      st_tag,
    output dcache_pkg::line_t     st_line,
    output logic                  miss_valid,
    output dcache_pkg::tag_t      miss_tag,
    output dcache_pkg::index_t    miss_index,
    output logic                  hazard
);
    import dcache_pkg::*;

    logic [`DCACHE_WAYS-1:0] way_hit;
    logic  hit;
    logic  hit_way;
    logic  done;
    line_t hit_line;
    line_t merged;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = rd_valid[w] & (rd_tag[w] == s1_tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_line = rd_line[hit_way];

    // byte merge of the store word into the hit line
    always_comb begin
        merged = hit_line;
        for (int b = 0; b < `DCACHE_WORD_BYTES; b++) begin
            if (s1_mask[b]) begin
                merged[s1_offset][b*8 +: 8] = s1_wdata[b*8 +: 8];
            end
        end
    end

    // stage 1 read data is stale while the pending store lands in its set
    assign hazard = st_wr_en & s1_valid & (s1_index == st_index);

    // tags do not change on a store, so only data reads need the hazard wait
    assign miss_valid = s1_valid & ~hit & ~hazard;
    assign miss_tag   = s1_tag;
    assign miss_index = s1_index;

    assign done = s1_valid & hit & ~freeze & ~hazard;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            resp_valid <= 1'b0;
            st_wr_en   <= 1'b0;
        end else begin
            resp_valid <= done;
            st_wr_en   <= done & (s1_op == OP_STORE);
        end
    end

    always_ff @(posedge clk) begin
        resp_rdata <= (s1_op == OP_LOAD) ? hit_line[s1_offset] : '0;
        st_way     <= hit_way;
        st_index   <= s1_index;
        st_tag     <= s1_tag;
        st_line    <= merged;
    end

endmodule

/* dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    // core request opcode
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } req_op_e;

    // miss handling sequence
    typedef enum logic [2:0] {
        RF_IDLE    = 3'd0,
        RF_WB      = 3'd1,
        RF_FETCH   = 3'd2,
        RF_INSTALL = 3'd3,
        RF_REPLAY  = 3'd4
    } refill_state_e;

    // address fields
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    // data
    typedef logic [8*`DCACHE_WORD_BYTES-1:0] word_t;
    typedef word_t [`DCACHE_LINE_WORDS-1:0] line_t;
    typedef logic [`DCACHE_WORD_BYTES-1:0] mask_t;

endpackage

/* dcache_refill.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_refill (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  miss_valid,
    input  dcache_pkg::tag_t      miss_tag,
    input  dcache_pkg::index_t    miss_index,
    input  logic                  victim_way,
    input  dcache_pkg::tag_t  [`DCACHE_WAYS-1:0] rd_tag,
    input  dcache_pkg::line_t [`DCACHE_WAYS-1:0] rd_line,
    input  logic [`DCACHE_WAYS-1:0] rd_valid,
    input  logic [`DCACHE_WAYS-1:0] rd_dirty,
    input  logic                  mem_rd_valid,
    input  dcache_pkg::word_t     mem_rd_data,
    output logic                  freeze,
    output logic                  rf_wr_en,
    output logic                  rf_way,
    output dcache_pkg::index_t    rf_index,
    output dcache_pkg::tag_t      rf_tag,
    output dcache_pkg::line_t     rf_line,
    output logic                  victim_flip,
    output logic                  mem_rd_req,
    output logic [`DCACHE_ADDR_W-1:0] mem_rd_addr,
    output logic                  mem_wr_valid,
    output logic [`DCACHE_ADDR_W-1:0] mem_wr_addr,
    output dcache_pkg::word_t     mem_wr_data
);
    import dcache_pkg::*;

    localparam int LINE_LSB = `DCACHE_OFFSET_W + `DCACHE_BYTE_W;

    refill_state_e state;
    offset_t beat;
    logic    start;
    logic    vic_wb;

    tag_t   lat_tag;
    index_t lat_index;
    logic   lat_way;
    tag_t   vic_tag;
    line_t  vic_line;
    line_t  fill_line;

    assign start  = (state == RF_IDLE) & miss_valid;
    assign vic_wb = rd_valid[victim_way] & rd_dirty[victim_way];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= RF_IDLE;
            beat       <= '0;
            mem_rd_req <= 1'b0;
        end else begin
            mem_rd_req <= 1'b0;
            case (state)
                RF_IDLE: begin
                    beat <= '0;
                    if (miss_valid && vic_wb) begin
                        state <= RF_WB;
                    end else if (miss_valid) begin
                        state      <= RF_FETCH;
                        mem_rd_req <= 1'b1;
                    end
                end
                RF_WB: begin
                    beat <= beat + offset_t'(1);
                    if (beat == '1) begin
                        state      <= RF_FETCH;
                        mem_rd_req <= 1'b1;
                    end
                end
                RF_FETCH: begin
                    if (mem_rd_valid) begin
                        beat <= beat + offset_t'(1);
                        if (beat == '1) begin
                            state <= RF_INSTALL;
                        end
                    end
                end
                RF_INSTALL: state <= RF_REPLAY;
                RF_REPLAY:  state <= RF_IDLE;
                default:    state <= RF_IDLE;
            endcase
        end
    end

    // victim is taken from the same read that reported the miss
    always_ff @(posedge clk) begin
        if (start) begin
            lat_tag   <= miss_tag;
            lat_index <= miss_index;
            lat_way   <= victim_way;
            vic_tag   <= rd_tag[victim_way];
            vic_line  <= rd_line[victim_way];
        end
        if (state == RF_FETCH && mem_rd_valid) begin
            fill_line[beat] <= mem_rd_data;
        end
    end

    assign freeze = (state != RF_IDLE) | miss_valid;

    // installed line is clean
    assign rf_wr_en    = (state == RF_INSTALL);
    assign victim_flip = (state == RF_INSTALL);
    assign rf_way      = lat_way;
    assign rf_index    = (state == RF_IDLE) ? miss_index : lat_index;
    assign rf_tag      = lat_tag;
    assign rf_line     = fill_line;

    assign mem_rd_addr  = {lat_tag, lat_index, {LINE_LSB{1'b0}}};
    assign mem_wr_valid = (state == RF_WB);
    assign mem_wr_addr  = {vic_tag, lat_index, {LINE_LSB{1'b0}}};
    assign mem_wr_data  = vic_line[beat];

endmodule

/* dcache_req_decode.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_req_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  dcache_pkg::req_op_e   req_op,
    input  logic [`DCACHE_ADDR_W-1:0] req_addr,
    input  dcache_pkg::word_t     req_wdata,
    input  dcache_pkg::mask_t     req_mask,
    input  logic                  freeze,
    input  logic                  hazard,
    output logic                  req_ready,
    output dcache_pkg::index_t    rd_index,
    output logic                  s1_valid,
    output dcache_pkg::req_op_e   s1_op,
    output dcache_pkg::tag_t      s1_tag,
    output dcache_pkg::index_t    s1_index,
    output dcache_pkg::offset_t   s1_offset,
    output dcache_pkg::word_t     s1_wdata,
    output dcache_pkg::mask_t     s1_mask
);
    import dcache_pkg::*;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    accept;

    // byte bits are dropped, accesses are word aligned
    assign {req_tag, req_index, req_offset} = req_addr[`DCACHE_ADDR_W-1:`DCACHE_BYTE_W];

    assign req_ready = ~(freeze | hazard);
    assign accept    = req_valid & req_ready;

    // a held request reads its own set again
    assign rd_index = req_ready ? req_index : s1_index;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
        end else if (req_ready) begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_op     <= req_op;
            s1_tag    <= req_tag;
            s1_index  <= req_index;
            s1_offset <= req_offset;
            s1_wdata  <= req_wdata;
            s1_mask   <= req_mask;
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  dcache_pkg::req_op_e   req_op,
    input  logic [`DCACHE_ADDR_W-1:0] req_addr,
    input  dcache_pkg::word_t     req_wdata,
    input  dcache_pkg::mask_t     req_mask,
    output logic                  req_ready,
    output logic                  resp_valid,
    output dcache_pkg::word_t     resp_rdata,
    output logic                  mem_rd_req,
    output logic [`DCACHE_ADDR_W-1:0] mem_rd_addr,
    input  logic                  mem_rd_valid,
    input  dcache_pkg::word_t     mem_rd_data,
    output logic                  mem_wr_valid,
    output logic [`DCACHE_ADDR_W-1:0] mem_wr_addr,
    output dcache_pkg::word_t     mem_wr_data
);
    import dcache_pkg::*;

    logic     freeze, hazard;
    index_t   dec_rd_index;
    logic     s1_valid;
    req_op_e  s1_op;
    tag_t     s1_tag;
    index_t   s1_index;
    offset_t  s1_offset;
    word_t    s1_wdata;
    mask_t    s1_mask;

    tag_t  [`DCACHE_WAYS-1:0] rd_tag;
    line_t [`DCACHE_WAYS-1:0] rd_line;
    logic  [`DCACHE_WAYS-1:0] rd_valid, rd_dirty;
    logic     victim_way;

    logic     st_wr_en, st_way;
    index_t   st_index;
    tag_t     st_tag;
    line_t    st_line;
    logic     miss_valid;
    tag_t     miss_tag;
    index_t   miss_index;

    logic     rf_wr_en, rf_way, victim_flip;
    index_t   rf_index;
    tag_t     rf_tag;
    line_t    rf_line;

    // refill has priority on the array port
    index_t   arr_rd_index, wr_index;
    logic     wr_en, wr_way, wr_dirty;
    tag_t     wr_tag;
    line_t    wr_line;

    assign arr_rd_index = freeze ? rf_index : dec_rd_index;
    assign wr_en    = rf_wr_en | st_wr_en;
    assign wr_way   = rf_wr_en ? rf_way : st_way;
    assign wr_index = rf_wr_en ? rf_index : st_index;
    assign wr_tag   = rf_wr_en ? rf_tag : st_tag;
    assign wr_line  = rf_wr_en ? rf_line : st_line;
    assign wr_dirty = ~rf_wr_en;

    dcache_req_decode decode_i (
        .clk, .rst, .req_valid, .req_op, .req_addr, .req_wdata, .req_mask,
        .freeze, .hazard, .req_ready, .rd_index(dec_rd_index),
        .s1_valid, .s1_op, .s1_tag, .s1_index, .s1_offset, .s1_wdata, .s1_mask
    );

    dcache_arrays arrays_i (
        .clk, .rst, .rd_index(arr_rd_index), .wr_en, .wr_way, .wr_index, .wr_tag,
        .wr_line, .wr_dirty, .victim_flip,
        .rd_tag, .rd_line, .rd_valid, .rd_dirty, .victim_way
    );

    dcache_lookup lookup_i (
        .clk, .rst, .s1_valid, .s1_op, .s1_tag, .s1_index, .s1_offset, .s1_wdata,
        .s1_mask, .rd_tag, .rd_line, .rd_valid, .freeze,
        .resp_valid, .resp_rdata, .st_wr_en, .st_way, .st_index, .st_tag, .st_line,
        .miss_valid, .miss_tag, .miss_index, .hazard
    );

    dcache_refill refill_i (
        .clk, .rst, .miss_valid, .miss_tag, .miss_index, .victim_way,
        .rd_tag, .rd_line, .rd_valid, .rd_dirty, .mem_rd_valid, .mem_rd_data,
        .freeze, .rf_wr_en, .rf_way, .rf_index, .rf_tag, .rf_line, .victim_flip,
        .mem_rd_req, .mem_rd_addr, .mem_wr_valid, .mem_wr_addr, .mem_wr_data
    );

endmodule

/* flist.f */
+incdir+.
dcache_pkg.sv
dcache_req_decode.sv
dcache_arrays.sv
dcache_lookup.sv
dcache_refill.sv
dcache_top.sv
tb_dcache_mem.sv
tb_dcache.sv

/* tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int TIMEOUT   = 200;
    localparam int RAND_REQS = 2000;

    logic    clk = 1'b0;
    logic    rst;
    logic    req_valid;
    req_op_e req_op;
    logic [`DCACHE_ADDR_W-1:0] req_addr;
    word_t   req_wdata;
    mask_t   req_mask;
    logic    req_ready;
    logic    resp_valid;
    word_t   resp_rdata;
    logic    mem_rd_req;
    logic [`DCACHE_ADDR_W-1:0] mem_rd_addr;
    logic    mem_rd_valid;
    word_t   mem_rd_data;
    logic    mem_wr_valid;
    logic [`DCACHE_ADDR_W-1:0] mem_wr_addr;
    word_t   mem_wr_data;

    // reference model and expected responses in acceptance order
    word_t       model_mem [int unsigned];
    word_t       exp_data[$];
    logic [31:0] exp_addr[$];
    int          exp_cycle[$];
    bit          exp_lat[$];
    word_t       wb_words[$];
    logic [31:0] wb_lines[$];

    int cycle = 0;
    int errors = 0;
    int mon_errors = 0;
    int accepted = 0;
    int responses = 0;
    int rd_reqs = 0;

    dcache_top dut_i (
        .clk, .rst, .req_valid, .req_op, .req_addr, .req_wdata, .req_mask,
        .req_ready, .resp_valid, .resp_rdata, .mem_rd_req, .mem_rd_addr,
        .mem_rd_valid, .mem_rd_data, .mem_wr_valid, .mem_wr_addr, .mem_wr_data
    );

    tb_dcache_mem mem_i (
        .clk, .rst, .rd_req(mem_rd_req), .rd_addr(mem_rd_addr),
        .rd_valid(mem_rd_valid), .rd_data(mem_rd_data),
        .wr_valid(mem_wr_valid), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic word_t init_word(input int unsigned waddr);
        return (waddr * 32'h9e37_79b9) ^ {waddr[15:0], waddr[31:16]};
    endfunction

    function automatic word_t model_read(input logic [31:0] addr);
        int unsigned w;
        w = addr >> 2;
        if (model_mem.exists(w)) begin
            return model_mem[w];
        end
        return init_word(w);
    endfunction

    task automatic model_store(input logic [31:0] addr, input word_t wdata, input mask_t mask);
        word_t w;
        w = model_read(addr);
        for (int b = 0; b < `DCACHE_WORD_BYTES; b++) begin
            if (mask[b]) begin
                w[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        model_mem[addr >> 2] = w;
    endtask

    // four tags in each of two sets so both ways fill and dirty lines get evicted
    function automatic logic [31:0] rand_addr();
        logic [31:0] a;
        a = 32'h0002_0000;
        a[9:8] = 2'($urandom_range(3, 0));
        a[7:4] = ($urandom_range(1, 0) == 1) ? 4'd3 : 4'd12;
        a[3:2] = 2'($urandom_range(3, 0));
        return a;
    endfunction

    task automatic send(input req_op_e op, input logic [31:0] addr, input word_t wdata,
                        input mask_t mask, input bit check_lat);
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_mask  = mask;
        while (!req_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            $display("ERROR at %0t: request to %08h never accepted, req_ready stayed low",
                     $time, addr);
            errors++;
            req_valid = 1'b0;
        end else begin
            // accepted in this cycle at the coming rising edge
            exp_addr.push_back(addr);
            exp_cycle.push_back(cycle);
            exp_lat.push_back(check_lat);
            if (op == OP_STORE) begin
                exp_data.push_back('0);
                model_store(addr, wdata, mask);
            end else begin
                exp_data.push_back(model_read(addr));
            end
            accepted++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (responses != accepted && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (responses != accepted) begin
            $display("ERROR at %0t: timed out waiting for responses, %0d accepted, %0d returned",
                     $time, accepted, responses);
            errors++;
        end
    endtask

    task automatic report(input int num, input string name, input int err_before);
        if (errors + mon_errors == err_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors + mon_errors - err_before);
        end
    endtask

    always @(negedge clk) begin : monitor
        word_t want;
        if (rst && mem_rd_req) begin
            rd_reqs++;
            // the oldest outstanding request is the one that missed
            if (responses < exp_addr.size() &&
                mem_rd_addr !== (exp_addr[responses] & ~32'hf)) begin
                $display("CHECK FAILED t=%0t: line read at %08h, expected %08h",
                         $time, mem_rd_addr, exp_addr[responses] & ~32'hf);
                mon_errors++;
            end
        end
        if (rst && mem_wr_valid) begin
            wb_words.push_back(mem_wr_data);
            wb_lines.push_back(mem_wr_addr);
        end
        if (rst && resp_valid) begin
            if (responses >= exp_data.size()) begin
                $display("ERROR at %0t: response seen with no accepted request outstanding", $time);
                mon_errors++;
            end else begin
                want = exp_data[responses];
                if (resp_rdata !== want) begin
                    $display("CHECK FAILED t=%0t: response for %08h is %08h, expected %08h",
                             $time, exp_addr[responses], resp_rdata, want);
                    mon_errors++;
                end
                if (exp_lat[responses] && cycle - exp_cycle[responses] != 2) begin
                    $display("CHECK FAILED t=%0t: hit latency %0d cycles, expected 2",
                             $time, cycle - exp_cycle[responses]);
                    mon_errors++;
                end
            end
            responses++;
        end
    end

    initial begin
        int          err_before;
        int          rd_before;
        int          wb_start;
        logic [31:0] addr;
        logic [31:0] victim;
        logic [31:0] b0;
        logic [31:0] b1;
        logic [31:0] b2;

        void'($urandom(32'h87eccd96));
        rst       = 1'b0;
        req_valid = 1'b0;
        req_op    = OP_LOAD;
        req_addr  = '0;
        req_wdata = '0;
        req_mask  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        err_before = errors + mon_errors;
        if (req_ready !== 1'b1 || resp_valid !== 1'b0 || mem_rd_req !== 1'b0 ||
            mem_wr_valid !== 1'b0) begin
            $display("CHECK FAILED t=%0t: after reset ready=%b resp=%b rd_req=%b wr=%b",
                     $time, req_ready, resp_valid, mem_rd_req, mem_wr_valid);
            errors++;
        end
        report(1, "reset state", err_before);

        // first load misses and the repeat hits in two cycles
        err_before = errors + mon_errors;
        addr = 32'h0000_4a28;
        rd_before = rd_reqs;
        send(OP_LOAD, addr, '0, '0, 1'b0);
        drain();
        if (rd_reqs - rd_before != 1) begin
            $display("CHECK FAILED t=%0t: %0d line reads for a cold miss, expected 1",
                     $time, rd_reqs - rd_before);
            errors++;
        end
        rd_before = rd_reqs;
        send(OP_LOAD, addr, '0, '0, 1'b1);
        drain();
        if (rd_reqs != rd_before) begin
            $display("CHECK FAILED t=%0t: hit load read memory", $time);
            errors++;
        end
        report(2, "miss then hit load", err_before);

        // back to back goes through the hazard stall
        err_before = errors + mon_errors;
        send(OP_STORE, addr, 32'hdead_beef, 4'b0101, 1'b0);
        send(OP_LOAD, addr, '0, '0, 1'b0);
        drain();
        send(OP_STORE, addr + 4, 32'h1234_5678, 4'b1010, 1'b0);
        idle(3);
        send(OP_LOAD, addr + 4, '0, '0, 1'b0);
        drain();
        report(3, "store then load", err_before);

        // three tags in set 9
        err_before = errors + mon_errors;
        b0 = 32'h0001_2094;
        b1 = 32'h0001_2198;
        b2 = 32'h0001_229c;
        send(OP_STORE, b0, 32'hcafe_f00d, 4'b1111, 1'b0);
        send(OP_STORE, b1, 32'h0bad_1dea, 4'b0011, 1'b0);
        drain();
        wb_start = wb_words.size();
        send(OP_LOAD, b2, '0, '0, 1'b0);
        drain();
        if (wb_words.size() - wb_start != `DCACHE_LINE_WORDS) begin
            $display("CHECK FAILED t=%0t: %0d write-back words, expected 4",
                     $time, wb_words.size() - wb_start);
            errors++;
        end else begin
            victim = wb_lines[wb_start];
            if (victim != (b0 & ~32'hf) && victim != (b1 & ~32'hf)) begin
                $display("CHECK FAILED t=%0t: write-back of line %08h, not a dirty line",
                         $time, victim);
                errors++;
            end
            for (int i = 0; i < `DCACHE_LINE_WORDS; i++) begin
                if (wb_words[wb_start + i] !== model_read(victim + 4 * i)) begin
                    $display("CHECK FAILED t=%0t: write-back word %0d is %08h, expected %08h",
                             $time, i, wb_words[wb_start + i], model_read(victim + 4 * i));
                    errors++;
                end
            end
        end
        send(OP_LOAD, b0, '0, '0, 1'b0);
        send(OP_LOAD, b1, '0, '0, 1'b0);
        send(OP_LOAD, b2, '0, '0, 1'b0);
        drain();
        report(4, "dirty eviction", err_before);

        err_before = errors + mon_errors;
        for (int i = 0; i < RAND_REQS; i++) begin
            addr = rand_addr();
            if ($urandom_range(1, 0) == 1) begin
                send(OP_STORE, addr, word_t'($urandom()), mask_t'($urandom()), 1'b0);
            end else begin
                send(OP_LOAD, addr, '0, '0, 1'b0);
            end
            if ($urandom_range(3, 0) == 0) begin
                idle($urandom_range(2, 1));
            end
        end
        drain();
        report(5, "random traffic", err_before);

        // cold misses hold the following requests while req_ready is low
        err_before = errors + mon_errors;
        send(OP_LOAD, 32'h0003_0040, '0, '0, 1'b0);
        send(OP_STORE, 32'h0003_0080, 32'h5a5a_a5a5, 4'b1001, 1'b0);
        send(OP_LOAD, 32'h0003_0080, '0, '0, 1'b0);
        drain();
        idle(4);
        if (responses != accepted) begin
            $display("CHECK FAILED t=%0t: %0d responses for %0d accepted requests",
                     $time, responses, accepted);
            errors++;
        end
        report(6, "response count", err_before);

        $display("summary: %0d requests, %0d responses, %0d errors",
                 accepted, responses, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb_dcache_mem.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache_mem (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_req,
    input  logic [`DCACHE_ADDR_W-1:0] rd_addr,
    output logic                      rd_valid,
    output dcache_pkg::word_t         rd_data,
    input  logic                      wr_valid,
    input  logic [`DCACHE_ADDR_W-1:0] wr_addr,
    input  dcache_pkg::word_t         wr_data
);
    import dcache_pkg::*;

    // untouched words of the sparse storage read the fill pattern
    word_t       mem [int unsigned];
    logic        busy;
    int unsigned rd_line;
    int          rd_beat;
    int          wait_cnt;
    int          wr_beat;

    function automatic word_t init_word(input int unsigned waddr);
        return (waddr * 32'h9e37_79b9) ^ {waddr[15:0], waddr[31:16]};
    endfunction

    function automatic word_t read_word(input int unsigned waddr);
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        return init_word(waddr);
    endfunction

    always @(negedge clk or negedge rst) begin
        if (!rst) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
            busy     = 1'b0;
            rd_beat  = 0;
            wait_cnt = 0;
            wr_beat  = 0;
        end else begin
            rd_valid <= 1'b0;
            // write-back beats arrive back to back with offset 0 first
            if (wr_valid) begin
                mem[(wr_addr >> 2) + wr_beat] = wr_data;
                wr_beat = (wr_beat + 1) % `DCACHE_LINE_WORDS;
            end else begin
                wr_beat = 0;
            end
            if (rd_req) begin
                busy     = 1'b1;
                rd_line  = rd_addr >> 2;
                rd_beat  = 0;
                wait_cnt = $urandom_range(6, 1);
            end else if (busy) begin
                if (wait_cnt > 0) begin
                    wait_cnt--;
                end else begin
                    rd_valid <= 1'b1;
                    rd_data  <= read_word(rd_line + rd_beat);
                    rd_beat++;
                    // random gap before the next beat
                    wait_cnt = $urandom_range(2, 0);
                    if (rd_beat == `DCACHE_LINE_WORDS) begin
                        busy = 1'b0;
                    end
                end
            end
        end
    end

endmodule
